//--- src/xr_defines.svh
`ifndef XR_DEFINES_SVH
`define XR_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// bus widths
////////////////////////////////////////////////////////////////////////////

// register offset on the basic bus
`define XR_ADDR_W 12

// basic bus data, user data port is the same width
`define XR_DATA_W 16

////////////////////////////////////////////////////////////////////////////
// protected offsets
////////////////////////////////////////////////////////////////////////////

// a direct-mode write to one of these offsets turns into a
// read-modify-write; mask bit set = bit keeps its current value

`define XR_PROT_OFST_0 12'h0a0  // clock buffer select
`define XR_PROT_MASK_0 16'hf000

`define XR_PROT_OFST_1 12'h0b2  // refclk mux
`define XR_PROT_MASK_1 16'h00ff

`define XR_PROT_OFST_2 12'h0c4  // cdr power and lock-to-ref
`define XR_PROT_MASK_2 16'h8001

`define XR_PROT_OFST_3 12'h1f0  // rx buffer trim
`define XR_PROT_MASK_3 16'h0f0f

// number of table entries above
`define XR_PROT_N 4

`endif

//--- src/xr_uif_pkg.sv
`include "xr_defines.svh"

package xr_uif_pkg;

  // user operation
  typedef enum logic {
    UIF_READ  = 1'b0,
    UIF_WRITE = 1'b1
  } uif_mode_t;

  // access style on the user port
  typedef enum logic [1:0] {
    UIF_ACC_STREAM   = 2'b00,  // no stream engine here, handled as raw
    UIF_ACC_DIRECT   = 2'b01,  // protected offsets get read-modify-write
    UIF_ACC_RAW_LOG  = 2'b10,
    UIF_ACC_RAW_PHYS = 2'b11
  } uif_access_t;

  // one accepted user request, 31 bits
  typedef struct packed {
    uif_mode_t             mode;
    uif_access_t           access;
    logic [`XR_ADDR_W-1:0] addr;
    logic [`XR_DATA_W-1:0] wdata;
  } uif_req_t;

endpackage

//--- src/xr_basic_pkg.sv
`include "xr_defines.svh"

package xr_basic_pkg;

  // basic bus opcode, only read and write are issued
  typedef enum logic [2:0] {
    BASIC_RD = 3'd0,
    BASIC_WR = 3'd1
  } basic_op_t;

  // command from the controller to the bus port, 32 bits
  //
  // lock is the level the port presents from this edge on: it is
  // taken at the start of an access and again at its end, so a
  // read-modify-write keeps lock up across the gap between accesses
  typedef struct packed {
    basic_op_t             opcode;
    logic [`XR_ADDR_W-1:0] addr;
    logic [`XR_DATA_W-1:0] wdata;
    logic                  lock;
  } basic_req_t;

endpackage

//--- src/xr_protect_table.sv
`include "xr_defines.svh"

module xr_protect_table (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  lookup,   // one-cycle strobe from controller
  input  logic [`XR_ADDR_W-1:0] addr,
  output logic                  protect,  // offset needs read-modify-write
  output logic [`XR_DATA_W-1:0] mask      // 1 = keep the current bit
);

  ////////////////////////////////////////////////////////////////////////////
  // table contents
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [`XR_ADDR_W-1:0] PROT_OFST [`XR_PROT_N] = '{
    `XR_PROT_OFST_0,
    `XR_PROT_OFST_1,
    `XR_PROT_OFST_2,
    `XR_PROT_OFST_3
  };

  localparam logic [`XR_DATA_W-1:0] PROT_MASK [`XR_PROT_N] = '{
    `XR_PROT_MASK_0,
    `XR_PROT_MASK_1,
    `XR_PROT_MASK_2,
    `XR_PROT_MASK_3
  };

  logic                  hit;
  logic [`XR_DATA_W-1:0] hit_mask;

  // offsets are distinct, so at most one entry matches
  always_comb begin
    hit      = 1'b0;
    hit_mask = '0;  // unprotected: every bit writable
    for (int i = 0; i < `XR_PROT_N; i++) begin
      if (addr == PROT_OFST[i]) begin
        hit      = 1'b1;
        hit_mask = hit_mask | PROT_MASK[i];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // result hold
  ////////////////////////////////////////////////////////////////////////////

  // held until the next lookup so the merge sees a stable mask
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      protect <= 1'b0;
      mask    <= '0;
    end else if (lookup) begin
      protect <= hit;
      mask    <= hit_mask;
    end
  end

endmodule

//--- src/xr_basic_port.sv
`include "xr_defines.svh"

module xr_basic_port (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,       // one-cycle request strobe
  input  xr_basic_pkg::basic_req_t  req,
  input  logic                      ctrl_wait,   // access still running
  input  logic [`XR_DATA_W-1:0]     ctrl_rdata,
  output logic                      ctrl_go,
  output xr_basic_pkg::basic_op_t   ctrl_opcode,
  output logic                      ctrl_lock,
  output logic [`XR_ADDR_W-1:0]     ctrl_addr,
  output logic [`XR_DATA_W-1:0]     ctrl_wdata,
  output logic                      done,        // access finished this cycle
  output logic [`XR_DATA_W-1:0]     rdata        // word from the last access
);

  typedef enum logic {
    PS_IDLE,
    PS_WAIT
  } port_state_t;

  port_state_t state;
  logic        launch;

  // a start is only taken while no access is in flight
  assign launch = start && (state == PS_IDLE);

  // the go cycle itself never ends an access
  assign done = (state == PS_WAIT) && !ctrl_go && !ctrl_wait;

  ////////////////////////////////////////////////////////////////////////////
  // access engine
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= PS_IDLE;
      ctrl_go     <= 1'b0;
      ctrl_opcode <= xr_basic_pkg::BASIC_RD;
      ctrl_lock   <= 1'b0;
    end else begin
      ctrl_go <= launch;  // single-cycle pulse
      if (launch) begin
        state       <= PS_WAIT;
        ctrl_opcode <= req.opcode;
        ctrl_lock   <= req.lock;
      end else if (done) begin
        state     <= PS_IDLE;
        ctrl_lock <= req.lock;  // stays up between rmw accesses
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus payload
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (launch) begin
      ctrl_addr  <= req.addr;
      ctrl_wdata <= req.wdata;
    end
  end

  // data is valid on the cycle wait drops
  always_ff @(posedge clk) begin
    if (done) begin
      rdata <= ctrl_rdata;
    end
  end

endmodule

//--- src/xr_direct_ctrl.sv
`include "xr_defines.svh"

module xr_direct_ctrl (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      uif_go,
  input  logic                      uif_mode,      // 0 read, 1 write
  input  logic [1:0]                uif_mif_mode,  // 01 direct, others raw
  input  logic [`XR_ADDR_W-1:0]     uif_addr,
  input  logic [`XR_DATA_W-1:0]     uif_wdata,
  input  logic                      protect,
  input  logic [`XR_DATA_W-1:0]     mask,
  input  logic                      done,
  input  logic [`XR_DATA_W-1:0]     rdata,
  output logic                      uif_busy,
  output logic [`XR_DATA_W-1:0]     uif_rdata,
  output logic                      lookup,
  output logic                      start,
  output xr_basic_pkg::basic_req_t  req
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOOKUP,   // direct write waits one cycle for the table
    ST_RD_WAIT,
    ST_WR_WAIT
  } ctrl_state_t;

  ctrl_state_t            state;
  ctrl_state_t            state_nxt;
  xr_uif_pkg::uif_req_t   new_req;
  xr_uif_pkg::uif_req_t   cur_req;
  logic                   accept;
  logic                   new_wr;
  logic                   new_direct_wr;
  logic                   rmw_cmd;
  logic                   wr_pend;    // rmw write goes out this cycle
  logic                   rd_load;    // user read word is in rdata
  logic [`XR_DATA_W-1:0]  merged;

  assign new_req.mode   = xr_uif_pkg::uif_mode_t'(uif_mode);
  assign new_req.access = xr_uif_pkg::uif_access_t'(uif_mif_mode);
  assign new_req.addr   = uif_addr;
  assign new_req.wdata  = uif_wdata;

  assign accept        = uif_go && (state == ST_IDLE);  // go while busy is dropped
  assign new_wr        = (new_req.mode == xr_uif_pkg::UIF_WRITE);
  assign new_direct_wr = new_wr && (new_req.access == xr_uif_pkg::UIF_ACC_DIRECT);
  assign rmw_cmd       = (cur_req.mode == xr_uif_pkg::UIF_WRITE) &&
                         (cur_req.access == xr_uif_pkg::UIF_ACC_DIRECT);

  assign lookup   = accept;
  assign uif_busy = (state != ST_IDLE);

  // preserved bits from the register, the rest from the user
  assign merged = (rdata & mask) | (cur_req.wdata & ~mask);

  ////////////////////////////////////////////////////////////////////////////
  // sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (accept) begin
          if (new_direct_wr) state_nxt = ST_LOOKUP;
          else if (new_wr)   state_nxt = ST_WR_WAIT;
          else               state_nxt = ST_RD_WAIT;
        end
      end
      ST_LOOKUP:  state_nxt = protect ? ST_RD_WAIT : ST_WR_WAIT;
      ST_RD_WAIT: begin
        if (rd_load)              state_nxt = ST_IDLE;
        else if (done && rmw_cmd) state_nxt = ST_WR_WAIT;
      end
      ST_WR_WAIT: if (done) state_nxt = ST_IDLE;
      default:    state_nxt = ST_IDLE;
    endcase
  end

  // bus command, lock follows the rmw sequence
  always_comb begin
    start       = 1'b0;
    req.opcode  = xr_basic_pkg::BASIC_RD;
    req.addr    = cur_req.addr;
    req.wdata   = cur_req.wdata;
    req.lock    = 1'b0;
    case (state)
      ST_IDLE: begin
        start     = accept && !new_direct_wr;  // reads and raw writes go at once
        req.addr  = uif_addr;
        req.wdata = uif_wdata;
        if (new_wr) req.opcode = xr_basic_pkg::BASIC_WR;
      end
      ST_LOOKUP: begin
        start = 1'b1;
        if (!protect) req.opcode = xr_basic_pkg::BASIC_WR;
        req.lock = protect;
      end
      ST_RD_WAIT: req.lock = rmw_cmd;  // keep lock past the read
      ST_WR_WAIT: begin
        start      = wr_pend;
        req.opcode = xr_basic_pkg::BASIC_WR;
        req.wdata  = merged;
        req.lock   = wr_pend;  // drops at the write's done
      end
      default: start = 1'b0;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= ST_IDLE;
      wr_pend   <= 1'b0;
      rd_load   <= 1'b0;
      uif_rdata <= '0;
    end else begin
      state   <= state_nxt;
      wr_pend <= (state == ST_RD_WAIT) && done && rmw_cmd;
      rd_load <= (state == ST_RD_WAIT) && done && !rmw_cmd;
      if (rd_load) uif_rdata <= rdata;  // same edge busy falls
    end
  end

  // request payload
  always_ff @(posedge clk) begin
    if (accept) cur_req <= new_req;
  end

endmodule

//--- src/xr_reconfig_top.sv
`include "xr_defines.svh"

module xr_reconfig_top (
  input  logic                  clk,
  input  logic                  reset,

  // user port
  input  logic                  uif_go,
  input  logic                  uif_mode,
  input  logic [1:0]            uif_mif_mode,
  input  logic [`XR_ADDR_W-1:0] uif_addr,
  input  logic [`XR_DATA_W-1:0] uif_wdata,
  output logic                  uif_busy,
  output logic [`XR_DATA_W-1:0] uif_rdata,

  // basic bus
  output logic                  ctrl_go,
  output logic [2:0]            ctrl_opcode,
  output logic                  ctrl_lock,
  output logic [`XR_ADDR_W-1:0] ctrl_addr,
  output logic [`XR_DATA_W-1:0] ctrl_wdata,
  input  logic                  ctrl_wait,
  input  logic [`XR_DATA_W-1:0] ctrl_rdata
);

  logic                     lookup;
  logic                     protect;
  logic [`XR_DATA_W-1:0]    mask;
  logic                     start;
  logic                     done;
  logic [`XR_DATA_W-1:0]    rdata;
  xr_basic_pkg::basic_req_t req;
  xr_basic_pkg::basic_op_t  opcode;

  assign ctrl_opcode = opcode;

  xr_protect_table table0 (
    .clk     (clk),
    .reset   (reset),
    .lookup  (lookup),
    .addr    (uif_addr),  // sampled only on the accept strobe
    .protect (protect),
    .mask    (mask)
  );

  xr_direct_ctrl ctrl0 (
    .clk          (clk),
    .reset        (reset),
    .uif_go       (uif_go),
    .uif_mode     (uif_mode),
    .uif_mif_mode (uif_mif_mode),
    .uif_addr     (uif_addr),
    .uif_wdata    (uif_wdata),
    .protect      (protect),
    .mask         (mask),
    .done         (done),
    .rdata        (rdata),
    .uif_busy     (uif_busy),
    .uif_rdata    (uif_rdata),
    .lookup       (lookup),
    .start        (start),
    .req          (req)
  );

  xr_basic_port port0 (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .req         (req),
    .ctrl_wait   (ctrl_wait),
    .ctrl_rdata  (ctrl_rdata),
    .ctrl_go     (ctrl_go),
    .ctrl_opcode (opcode),
    .ctrl_lock   (ctrl_lock),
    .ctrl_addr   (ctrl_addr),
    .ctrl_wdata  (ctrl_wdata),
    .done        (done),
    .rdata       (rdata)
  );

endmodule

//--- tb/xr_sva.sv
module xr_sva (
  input logic                    clk,
  input logic                    reset,
  input logic                    ctrl_go,
  input logic                    ctrl_lock,
  input logic                    done,
  input xr_basic_pkg::basic_op_t ctrl_opcode
);

  logic in_flight;  // an access was issued and has not seen done yet

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      in_flight <= 1'b0;
    end else if (ctrl_go) begin
      in_flight <= 1'b1;
    end else if (done) begin
      in_flight <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus protocol
  ////////////////////////////////////////////////////////////////////////////

  a_go_single: assert property (@(posedge clk) disable iff (reset)
    ctrl_go |=> !ctrl_go)
    else $error("ctrl_go held high for two cycles");

  a_go_after_done: assert property (@(posedge clk) disable iff (reset)
    ctrl_go |-> !in_flight)
    else $error("ctrl_go issued before the previous access finished");

  // lock may only drop right after a write completes
  a_lock_hold: assert property (@(posedge clk) disable iff (reset)
    (ctrl_lock && !(done && ctrl_opcode == xr_basic_pkg::BASIC_WR)) |=> ctrl_lock)
    else $error("ctrl_lock dropped inside a read-modify-write");

endmodule

//--- tb/xr_tb.sv
`include "xr_defines.svh"

module xr_tb;

  localparam int         TIMEOUT    = 40;  // cycles per wait loop
  localparam logic [1:0] ACC_DIRECT = 2'b01;
  localparam logic [1:0] ACC_RAW    = 2'b10;
  localparam logic [1:0] ACC_RAW_PH = 2'b11;
  localparam logic       MODE_RD    = 1'b0;
  localparam logic       MODE_WR    = 1'b1;

  logic                  clk = 1'b0;
  logic                  reset;
  logic                  uif_go;
  logic                  uif_mode;
  logic [1:0]            uif_mif_mode;
  logic [`XR_ADDR_W-1:0] uif_addr;
  logic [`XR_DATA_W-1:0] uif_wdata;
  logic                  uif_busy;
  logic [`XR_DATA_W-1:0] uif_rdata;
  logic                  ctrl_go;
  logic [2:0]            ctrl_opcode;
  logic                  ctrl_lock;
  logic [`XR_ADDR_W-1:0] ctrl_addr;
  logic [`XR_DATA_W-1:0] ctrl_wdata;
  logic                  ctrl_wait  = 1'b0;
  logic [`XR_DATA_W-1:0] ctrl_rdata = '0;

  // register model
  logic [`XR_DATA_W-1:0] mem [2**`XR_ADDR_W];
  integer                seed          = 45;
  int                    preset_gen    = 0;  // bumped by a test to reload
  int                    preset_seen   = 0;
  int                    go_count      = 0;
  int                    rd_count      = 0;
  int                    lock_go_count = 0;  // go pulses seen with lock up
  int                    lock_cycles   = 0;
  logic                  acc_busy      = 1'b0;
  logic                  acc_write     = 1'b0;
  logic [`XR_ADDR_W-1:0] acc_addr      = '0;
  logic [`XR_DATA_W-1:0] acc_wdata     = '0;
  int                    wait_left     = 0;

  // bookkeeping of the test flow
  int test_errors;
  int pass_count;
  int fail_count;
  int go_base;
  int rd_base;
  int lock_go_base;
  int lock_cyc_base;

  always #5 clk = ~clk;

  xr_reconfig_top dut0 (
    .clk          (clk),
    .reset        (reset),
    .uif_go       (uif_go),
    .uif_mode     (uif_mode),
    .uif_mif_mode (uif_mif_mode),
    .uif_addr     (uif_addr),
    .uif_wdata    (uif_wdata),
    .uif_busy     (uif_busy),
    .uif_rdata    (uif_rdata),
    .ctrl_go      (ctrl_go),
    .ctrl_opcode  (ctrl_opcode),
    .ctrl_lock    (ctrl_lock),
    .ctrl_addr    (ctrl_addr),
    .ctrl_wdata   (ctrl_wdata),
    .ctrl_wait    (ctrl_wait),
    .ctrl_rdata   (ctrl_rdata)
  );

  bind xr_basic_port xr_sva sva0 (
    .clk         (clk),
    .reset       (reset),
    .ctrl_go     (ctrl_go),
    .ctrl_lock   (ctrl_lock),
    .done        (done),
    .ctrl_opcode (ctrl_opcode)
  );

  // unique word per offset
  function automatic logic [`XR_DATA_W-1:0] preset_word(input logic [`XR_ADDR_W-1:0] addr);
    preset_word = {addr[3:0], addr} ^ 16'h5ac3;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // basic bus register model
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    #1;
    if (preset_seen != preset_gen) begin
      for (int i = 0; i < 2**`XR_ADDR_W; i++) begin
        mem[i] = preset_word(i[`XR_ADDR_W-1:0]);
      end
      preset_seen = preset_gen;
    end
    if (ctrl_lock) lock_cycles = lock_cycles + 1;
    if (ctrl_go) begin
      go_count = go_count + 1;
      if (ctrl_opcode == 3'd0) rd_count = rd_count + 1;
      if (ctrl_lock) lock_go_count = lock_go_count + 1;
      acc_busy  = 1'b1;
      acc_write = (ctrl_opcode == 3'd1);
      acc_addr  = ctrl_addr;
      acc_wdata = ctrl_wdata;
      wait_left = $unsigned($random(seed)) % 4;  // 0 to 3 wait cycles
      ctrl_wait = 1'b0;
    end else if (acc_busy && wait_left > 0) begin
      ctrl_wait = 1'b1;
      wait_left = wait_left - 1;
    end else if (acc_busy) begin
      ctrl_wait  = 1'b0;  // access ends this cycle
      ctrl_rdata = mem[acc_addr];
      if (acc_write) mem[acc_addr] = acc_wdata;
      acc_busy = 1'b0;
    end else begin
      ctrl_wait = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    $display("ERROR %s: %s expected %0h actual %0h", name, what, exp, act);
    test_errors = test_errors + 1;
  endtask

  task automatic load_presets(input string name);
    int cycles;
    cycles     = 0;
    preset_gen = preset_gen + 1;
    while (preset_seen != preset_gen && cycles < TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles = cycles + 1;
    end
    if (preset_seen != preset_gen) begin
      $display("%s: register model did not load its preset values", name);
      test_errors = test_errors + 1;
    end
  endtask

  task automatic snapshot_counts();
    go_base       = go_count;
    rd_base       = rd_count;
    lock_go_base  = lock_go_count;
    lock_cyc_base = lock_cycles;
  endtask

  task automatic drive_request(input logic mode, input logic [1:0] acc,
                               input logic [`XR_ADDR_W-1:0] addr,
                               input logic [`XR_DATA_W-1:0] wdata);
    uif_go       = 1'b1;
    uif_mode     = mode;
    uif_mif_mode = acc;
    uif_addr     = addr;
    uif_wdata    = wdata;
  endtask

  // one-cycle uif_go, busy must follow on the same edge
  task automatic start_op(input string name, input logic mode, input logic [1:0] acc,
                          input logic [`XR_ADDR_W-1:0] addr,
                          input logic [`XR_DATA_W-1:0] wdata);
    drive_request(mode, acc, addr, wdata);
    @(posedge clk);
    #1;
    uif_go = 1'b0;
    if (uif_busy !== 1'b1) begin
      $display("%s: uif_busy did not rise after uif_go", name);
      test_errors = test_errors + 1;
    end
  endtask

  task automatic wait_idle(input string name);
    int cycles;
    cycles = 0;
    while (uif_busy !== 1'b0 && cycles < TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles = cycles + 1;
    end
    if (uif_busy !== 1'b0) begin
      $display("%s: uif_busy still high after %0d cycles", name, TIMEOUT);
      test_errors = test_errors + 1;
    end
  endtask

  task automatic check_bus_counts(input string name, input int exp_go, input int exp_rd,
                                  input int exp_lock_go);
    if (go_count - go_base != exp_go)
      report_mismatch(name, "go pulses", 32'(exp_go), 32'(go_count - go_base));
    if (rd_count - rd_base != exp_rd)
      report_mismatch(name, "bus reads", 32'(exp_rd), 32'(rd_count - rd_base));
    if (lock_go_count - lock_go_base != exp_lock_go)
      report_mismatch(name, "go pulses with lock", 32'(exp_lock_go),
                      32'(lock_go_count - lock_go_base));
    if (exp_lock_go == 0 && lock_cycles != lock_cyc_base)
      report_mismatch(name, "cycles with lock", 32'(0), 32'(lock_cycles - lock_cyc_base));
  endtask

  task automatic end_test(input string name);
    if (test_errors == 0) begin
      $display("pass  %s", name);
      pass_count = pass_count + 1;
    end else begin
      $display("fail  %s (%0d errors)", name, test_errors);
      fail_count = fail_count + 1;
    end
    test_errors = 0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_state_check();
    string name;
    name = "reset_state";
    if (uif_busy !== 1'b0) report_mismatch(name, "uif_busy", 32'(0), 32'(uif_busy));
    if (ctrl_go !== 1'b0) report_mismatch(name, "ctrl_go", 32'(0), 32'(ctrl_go));
    if (ctrl_lock !== 1'b0) report_mismatch(name, "ctrl_lock", 32'(0), 32'(ctrl_lock));
    if (uif_rdata !== '0) report_mismatch(name, "uif_rdata", 32'(0), 32'(uif_rdata));
    if (ctrl_opcode !== 3'd0) report_mismatch(name, "ctrl_opcode", 32'(0), 32'(ctrl_opcode));
    end_test(name);
  endtask

  task automatic reads_direct_and_raw();
    string                 name;
    logic [`XR_ADDR_W-1:0] addr;
    name = "reads";
    load_presets(name);
    addr = 12'h345;
    snapshot_counts();
    start_op(name, MODE_RD, ACC_DIRECT, addr, 16'h0000);
    wait_idle(name);
    if (uif_rdata !== preset_word(addr))
      report_mismatch(name, "direct read data", 32'(preset_word(addr)), 32'(uif_rdata));
    check_bus_counts(name, 1, 1, 0);
    addr = `XR_PROT_OFST_1;  // raw read of a protected offset
    snapshot_counts();
    start_op(name, MODE_RD, ACC_RAW, addr, 16'h0000);
    wait_idle(name);
    if (uif_rdata !== preset_word(addr))
      report_mismatch(name, "raw read data", 32'(preset_word(addr)), 32'(uif_rdata));
    check_bus_counts(name, 1, 1, 0);
    end_test(name);
  endtask

  task automatic raw_write_plain();
    string name;
    name = "raw_write_unprotected";
    load_presets(name);
    snapshot_counts();
    start_op(name, MODE_WR, ACC_RAW, 12'h123, 16'hbeef);
    wait_idle(name);
    if (mem[12'h123] !== 16'hbeef)
      report_mismatch(name, "stored word", 32'(16'hbeef), 32'(mem[12'h123]));
    check_bus_counts(name, 1, 0, 0);
    end_test(name);
  endtask

  task automatic direct_write_protected();
    string                 name;
    logic [`XR_ADDR_W-1:0] ofst [4];
    logic [`XR_DATA_W-1:0] msk [4];
    logic [`XR_DATA_W-1:0] wd [4];
    logic [`XR_DATA_W-1:0] exp;
    name    = "direct_write_protected";
    ofst[0] = `XR_PROT_OFST_0;
    ofst[1] = `XR_PROT_OFST_1;
    ofst[2] = `XR_PROT_OFST_2;
    ofst[3] = `XR_PROT_OFST_3;
    msk[0]  = `XR_PROT_MASK_0;
    msk[1]  = `XR_PROT_MASK_1;
    msk[2]  = `XR_PROT_MASK_2;
    msk[3]  = `XR_PROT_MASK_3;
    wd[0]   = 16'h3cc3;
    wd[1]   = 16'ha5a5;
    wd[2]   = 16'h7ffe;
    wd[3]   = 16'hffff;
    load_presets(name);
    for (int i = 0; i < 4; i++) begin
      exp = (preset_word(ofst[i]) & msk[i]) | (wd[i] & ~msk[i]);
      snapshot_counts();
      start_op(name, MODE_WR, ACC_DIRECT, ofst[i], wd[i]);
      wait_idle(name);
      if (mem[ofst[i]] !== exp)
        report_mismatch(name, "merged word", 32'(exp), 32'(mem[ofst[i]]));
      check_bus_counts(name, 2, 1, 2);  // read then write, both locked
    end
    end_test(name);
  endtask

  task automatic raw_write_protected();
    string name;
    name = "raw_write_protected";
    load_presets(name);
    snapshot_counts();
    start_op(name, MODE_WR, ACC_RAW_PH, `XR_PROT_OFST_2, 16'h7ffe);
    wait_idle(name);
    if (mem[`XR_PROT_OFST_2] !== 16'h7ffe)
      report_mismatch(name, "stored word", 32'(16'h7ffe), 32'(mem[`XR_PROT_OFST_2]));
    check_bus_counts(name, 1, 0, 0);
    end_test(name);
  endtask

  task automatic direct_write_plain();
    string name;
    name = "direct_write_unprotected";
    load_presets(name);
    snapshot_counts();
    start_op(name, MODE_WR, ACC_DIRECT, 12'h0a1, 16'h1357);  // next to a protected one
    wait_idle(name);
    if (mem[12'h0a1] !== 16'h1357)
      report_mismatch(name, "stored word", 32'(16'h1357), 32'(mem[12'h0a1]));
    check_bus_counts(name, 1, 0, 0);
    end_test(name);
  endtask

  task automatic go_while_busy();
    string                 name;
    logic [`XR_DATA_W-1:0] exp;
    name = "go_while_busy";
    load_presets(name);
    exp = (preset_word(`XR_PROT_OFST_3) & `XR_PROT_MASK_3) | (16'h2468 & ~`XR_PROT_MASK_3);
    snapshot_counts();
    drive_request(MODE_WR, ACC_DIRECT, `XR_PROT_OFST_3, 16'h2468);
    @(posedge clk);
    #1;
    if (uif_busy !== 1'b1) begin
      $display("%s: uif_busy did not rise after uif_go", name);
      test_errors = test_errors + 1;
    end
    drive_request(MODE_WR, ACC_RAW, 12'h200, 16'hdead);  // must be dropped
    @(posedge clk);
    #1;
    uif_go = 1'b0;
    wait_idle(name);
    if (mem[`XR_PROT_OFST_3] !== exp)
      report_mismatch(name, "merged word", 32'(exp), 32'(mem[`XR_PROT_OFST_3]));
    if (mem[12'h200] !== preset_word(12'h200))
      report_mismatch(name, "untouched word", 32'(preset_word(12'h200)), 32'(mem[12'h200]));
    check_bus_counts(name, 2, 1, 2);
    end_test(name);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    reset        = 1'b1;
    uif_go       = 1'b0;
    uif_mode     = MODE_RD;
    uif_mif_mode = ACC_DIRECT;
    uif_addr     = '0;
    uif_wdata    = '0;
    test_errors  = 0;
    pass_count   = 0;
    fail_count   = 0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    reset_state_check();
    reads_direct_and_raw();
    raw_write_plain();
    direct_write_protected();
    raw_write_protected();
    direct_write_plain();
    go_while_busy();

    $display("tests %0d, passed %0d, failed %0d", pass_count + fail_count, pass_count,
             fail_count);
    if (fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+src
src/xr_uif_pkg.sv
src/xr_basic_pkg.sv
src/xr_protect_table.sv
src/xr_basic_port.sv
src/xr_direct_ctrl.sv
src/xr_reconfig_top.sv
tb/xr_sva.sv
tb/xr_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the xr_tb simulation with Verilator.

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=xr_sim

verilator --binary --assert --top-module xr_tb -f filelist.f -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "run.sh: verilator build failed with status $status"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "run.sh: simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  echo "run.sh: failure reported, see $LOG"
  exit 1
fi

if ! grep -q "TEST OK" "$LOG"; then
  echo "run.sh: simulation ended without a result line"
  exit 1
fi

echo "run.sh: simulation passed"
exit 0
